// ==== echo_params.svh ====
// UDP echo parameters
`ifndef ECHO_PARAMS_SVH
`define ECHO_PARAMS_SVH

// UDP destination port that gets echoed
`define ECHO_PORT   16'd1234

// Local address, 192.168.1.128
`define LOCAL_IP    {8'd192, 8'd168, 8'd1, 8'd128}

`define REPLY_TTL   8'd64     // Fixed TTL of every reply

// Payload FIFO depth in beats, power of two
`define FIFO_DEPTH  64

`endif

// ==== udp_hdr_pkg.sv ====
// UDP header types
`default_nettype none

package udp_hdr_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Header as handed over by the UDP stack
    typedef struct packed {
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] length;    // UDP length, header included
        logic [15:0] checksum;
    } rx_udp_hdr_t;

    // Header of an outgoing reply
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [7:0]  ttl;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] length;
        logic [15:0] checksum;  // Zero means not computed
    } tx_udp_hdr_t;

endpackage

`default_nettype wire

// ==== stream_pkg.sv ====
// Payload stream types
`default_nettype none

package stream_pkg;

    // One byte of datagram payload
    typedef struct packed {
        logic [7:0] data;
        logic       last;   // Final byte of the datagram
        logic       user;   // Error flag from upstream
    } payload_beat_t;

endpackage

`default_nettype wire

// ==== port_filter.sv ====
// Echo port filter
`timescale 1ns/10ps
`default_nettype none

`include "echo_params.svh"

module port_filter
    import udp_hdr_pkg::*, stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  rx_udp_hdr_t   in_hdr,
    input  logic          in_hdr_valid,
    output logic          in_hdr_ready,
    input  payload_beat_t in_payload,
    input  logic          in_payload_valid,
    output logic          in_payload_ready,

    output rx_udp_hdr_t   fwd_hdr,
    output logic          fwd_hdr_valid,
    input  logic          fwd_hdr_ready,
    output payload_beat_t fwd_payload,
    output logic          fwd_payload_valid,
    input  logic          fwd_payload_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for a header
        ST_FWD,     // Passing payload to the FIFO
        ST_DROP     // Swallowing payload
    } state_t;

    state_t state;
    logic   match;
    logic   hdr_xfer;
    logic   last_xfer;

    assign match = (in_hdr.dst_port == `ECHO_PORT);

    assign hdr_xfer  = in_hdr_valid && in_hdr_ready;
    assign last_xfer = in_payload_valid && in_payload_ready && in_payload.last;

    // Header and data pass straight through, only the handshakes are gated
    assign fwd_hdr     = in_hdr;
    assign fwd_payload = in_payload;

    always_comb begin
        in_hdr_ready      = 1'b0;
        fwd_hdr_valid     = 1'b0;
        in_payload_ready  = 1'b0;
        fwd_payload_valid = 1'b0;
        case (state)
            ST_IDLE: begin
                // Foreign ports are taken at once
                in_hdr_ready  = match ? fwd_hdr_ready : 1'b1;
                fwd_hdr_valid = in_hdr_valid && match;
            end
            ST_FWD: begin
                in_payload_ready  = fwd_payload_ready;
                fwd_payload_valid = in_payload_valid;
            end
            ST_DROP: in_payload_ready = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (hdr_xfer) state <= match ? ST_FWD : ST_DROP;
                ST_FWD,
                ST_DROP: if (last_xfer) state <= ST_IDLE;  // Reopen after last beat
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== reply_hdr_reg.sv ====
// Reply header stage
`timescale 1ns/10ps
`default_nettype none

`include "echo_params.svh"

module reply_hdr_reg
    import udp_hdr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  rx_udp_hdr_t in_hdr,
    input  logic        in_valid,
    output logic        in_ready,

    output tx_udp_hdr_t out_hdr,
    output logic        out_valid,
    input  logic        out_ready
);

    tx_udp_hdr_t reply;

    // Reply fields from the received header
    always_comb begin
        reply          = '0;        // DSCP, ECN and checksum stay zero
        reply.ttl      = `REPLY_TTL;
        reply.src_ip   = `LOCAL_IP;
        reply.dst_ip   = in_hdr.src_ip;
        reply.src_port = in_hdr.dst_port;
        reply.dst_port = in_hdr.src_port;
        reply.length   = in_hdr.length;
    end

    // Empty, or emptying this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_hdr <= reply;
        end
    end

endmodule

`default_nettype wire

// ==== payload_fifo.sv ====
// Payload beat FIFO
`timescale 1ns/10ps
`default_nettype none

module payload_fifo
    import stream_pkg::*;
#(
    parameter int DEPTH = 64
) (
    input  logic          clk,
    input  logic          rst,

    input  payload_beat_t in_beat,
    input  logic          in_valid,
    output logic          in_ready,

    output payload_beat_t out_beat,
    output logic          out_valid,
    input  logic          out_ready
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [CW-1:0] FULL_COUNT = CW'(DEPTH);

    payload_beat_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;      // Beats held in memory, output register excluded

    logic wr;
    logic out_free;
    logic rd_mem;
    logic bypass;
    logic wr_mem;

    assign in_ready = (count != FULL_COUNT);
    assign wr       = in_valid && in_ready;
    assign out_free = !out_valid || out_ready;    // Output register can load
    assign rd_mem   = out_free && (count != '0);
    assign bypass   = out_free && (count == '0) && wr;
    assign wr_mem   = wr && !bypass;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr_mem) wr_ptr <= wr_ptr + 1'b1;    // Pointers wrap on power of two
            if (rd_mem) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_mem, rd_mem})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (out_free) begin
                out_valid <= rd_mem || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mem) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Older beats in memory go first, else an empty FIFO loads directly
    always_ff @(posedge clk) begin
        if (rd_mem) begin
            out_beat <= mem[rd_ptr];
        end else if (bypass) begin
            out_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

// ==== led_capture.sv ====
// First byte LED latch
`timescale 1ns/10ps
`default_nettype none

module led_capture
    import stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  payload_beat_t beat,
    input  logic          beat_valid,
    input  logic          beat_ready,

    output logic [7:0]    led
);

    logic first;    // Next accepted beat opens a datagram

    always_ff @(posedge clk) begin
        if (rst) begin
            first <= 1'b1;
            led   <= '0;
        end else if (beat_valid && beat_ready) begin
            if (first) begin
                led <= beat.data;
            end
            first <= beat.last;     // Rearm after the final byte
        end
    end

endmodule

`default_nettype wire

// ==== udp_echo_top.sv ====
// UDP echo path top level
`timescale 1ns/10ps
`default_nettype none

`include "echo_params.svh"

module udp_echo_top
    import udp_hdr_pkg::*, stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  rx_udp_hdr_t   rx_hdr,
    input  logic          rx_hdr_valid,
    output logic          rx_hdr_ready,

    input  payload_beat_t rx_payload,
    input  logic          rx_payload_valid,
    output logic          rx_payload_ready,

    output tx_udp_hdr_t   tx_hdr,
    output logic          tx_hdr_valid,
    input  logic          tx_hdr_ready,

    output payload_beat_t tx_payload,
    output logic          tx_payload_valid,
    input  logic          tx_payload_ready,

    output logic [7:0]    led
);

    rx_udp_hdr_t   fwd_hdr;       // Matched header towards the reply stage
    logic          fwd_hdr_valid;
    logic          fwd_hdr_ready;

    payload_beat_t fwd_payload;   // Gated payload towards the FIFO
    logic          fwd_payload_valid;
    logic          fwd_payload_ready;

    port_filter u_filter (
        .clk               (clk),
        .rst               (rst),
        .in_hdr            (rx_hdr),
        .in_hdr_valid      (rx_hdr_valid),
        .in_hdr_ready      (rx_hdr_ready),
        .in_payload        (rx_payload),
        .in_payload_valid  (rx_payload_valid),
        .in_payload_ready  (rx_payload_ready),
        .fwd_hdr           (fwd_hdr),
        .fwd_hdr_valid     (fwd_hdr_valid),
        .fwd_hdr_ready     (fwd_hdr_ready),
        .fwd_payload       (fwd_payload),
        .fwd_payload_valid (fwd_payload_valid),
        .fwd_payload_ready (fwd_payload_ready)
    );

    reply_hdr_reg u_reply_hdr (
        .clk       (clk),
        .rst       (rst),
        .in_hdr    (fwd_hdr),
        .in_valid  (fwd_hdr_valid),
        .in_ready  (fwd_hdr_ready),
        .out_hdr   (tx_hdr),
        .out_valid (tx_hdr_valid),
        .out_ready (tx_hdr_ready)
    );

    payload_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fwd_payload),
        .in_valid  (fwd_payload_valid),
        .in_ready  (fwd_payload_ready),
        .out_beat  (tx_payload),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready)
    );

    // Watches the reply payload only
    led_capture u_led (
        .clk        (clk),
        .rst        (rst),
        .beat       (tx_payload),
        .beat_valid (tx_payload_valid),
        .beat_ready (tx_payload_ready),
        .led        (led)
    );

endmodule

`default_nettype wire

// ==== udp_echo_tasks.svh ====
// Echo testbench tasks
`ifndef UDP_ECHO_TASKS_SVH
`define UDP_ECHO_TASKS_SVH

// Reply expected for a received header
function automatic tx_udp_hdr_t expected_reply(input rx_udp_hdr_t h);
    tx_udp_hdr_t r;
    r          = '0;
    r.ttl      = 8'd64;
    r.src_ip   = {8'd192, 8'd168, 8'd1, 8'd128};
    r.dst_ip   = h.src_ip;
    r.src_port = h.dst_port;
    r.dst_port = h.src_port;
    r.length   = h.length;
    return r;
endfunction

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
        misc_errors++;
        $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic send_datagram(input ip_addr_t src_ip, input udp_port_t src_port,
                             input udp_port_t dst_port, input int len, input bit gaps);
    rx_udp_hdr_t   h;
    payload_beat_t beats[$];
    payload_beat_t b;
    int            i;
    h.src_ip   = src_ip;
    h.dst_ip   = {8'd192, 8'd168, 8'd1, 8'd128};
    h.src_port = src_port;
    h.dst_port = dst_port;
    h.length   = 16'(len + 8);    // UDP header counts too
    h.checksum = 16'($urandom);
    for (i = 0; i < len; i++) begin
        b.data = 8'($urandom);
        b.last = (i == len - 1);
        b.user = ($urandom % 8) == 0;
        beats.push_back(b);
    end
    if (dst_port == 16'd1234) begin
        exp_hdr_q.push_back(expected_reply(h));
        foreach (beats[j]) exp_beat_q.push_back(beats[j]);
        sent_first = beats[0].data;
    end
    @(posedge clk);
    rx_hdr       <= h;
    rx_hdr_valid <= 1'b1;
    do @(posedge clk); while (!rx_hdr_ready);
    rx_hdr_valid <= 1'b0;
    foreach (beats[j]) begin
        if (gaps && ($urandom % 4) == 0) begin
            rx_payload_valid <= 1'b0;     // Idle cycle between beats
            @(posedge clk);
        end
        rx_payload       <= beats[j];
        rx_payload_valid <= 1'b1;
        do @(posedge clk); while (!rx_payload_ready);
    end
    rx_payload_valid <= 1'b0;
endtask

// Lets the reply payload go once a full FIFO has stalled the input
task automatic release_when_full();
    bit stalled;
    bit done;
    stalled = 1'b0;
    done    = 1'b0;
    while (!stalled && !done) begin
        @(posedge clk);
        stalled = rx_payload_valid && !rx_payload_ready;
        done    = rx_payload_valid && rx_payload_ready && rx_payload.last;
    end
    hold_payload <= 1'b0;
    assert (stalled) else begin
        misc_errors++;
        $display("The input payload was never stalled by a full FIFO at %0t", $time);
    end
endtask

// Until every expected reply has come out
task automatic wait_drained();
    while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
endtask

task automatic test_reset_state();
    @(negedge clk);
    check_value(tx_hdr_valid, 1'b0, "tx_hdr_valid");
    check_value(tx_payload_valid, 1'b0, "tx_payload_valid");
    check_value(led, 8'h00, "led");
    check_value(rx_hdr_ready, 1'b1, "rx_hdr_ready");
endtask

task automatic test_single_echo();
    send_datagram({8'd10, 8'd0, 8'd0, 8'd7}, 16'd40000, 16'd1234, 16, 1'b0);
    wait_drained();
endtask

task automatic test_drop_then_echo();
    send_datagram({8'd10, 8'd0, 8'd0, 8'd8}, 16'd40001, 16'd5678, 20, 1'b1);
    send_datagram({8'd10, 8'd0, 8'd0, 8'd9}, 16'd40002, 16'd1234, 12, 1'b0);
    wait_drained();
endtask

task automatic test_backpressure();
    random_ready <= 1'b1;
    send_datagram({8'd172, 8'd16, 8'd0, 8'd1}, 16'd5001, 16'd1234, 5, 1'b1);
    hold_payload <= 1'b1;     // Long datagram runs into a full FIFO
    fork
        send_datagram({8'd172, 8'd16, 8'd0, 8'd2}, 16'd5002, 16'd1234, LONG_LEN, 1'b0);
        release_when_full();
    join
    send_datagram({8'd172, 8'd16, 8'd0, 8'd3}, 16'd5003, 16'd1234, 1, 1'b0);
    send_datagram({8'd172, 8'd16, 8'd0, 8'd4}, 16'd5004, 16'd1234, 30, 1'b1);
    wait_drained();
    random_ready <= 1'b0;
    repeat (2) @(posedge clk);
endtask

// LED keeps the echoed first byte across a dropped datagram
task automatic test_led_hold();
    logic [7:0] first;
    send_datagram({8'd10, 8'd1, 8'd1, 8'd1}, 16'd6000, 16'd1234, 8, 1'b1);
    first = sent_first;
    send_datagram({8'd10, 8'd1, 8'd1, 8'd2}, 16'd6001, 16'd80, 10, 1'b0);
    wait_drained();
    @(negedge clk);
    check_value(led, first, "led after dropped datagram");
endtask

`endif

// ==== tb_udp_echo.sv ====
// UDP echo testbench
`timescale 1ns/10ps
`default_nettype none

`include "echo_params.svh"

module tb_udp_echo
    import udp_hdr_pkg::*, stream_pkg::*;
();

    localparam int LONG_LEN    = `FIFO_DEPTH + 20;   // Forces the FIFO to fill
    localparam int TOTAL_BYTES = 16 + 20 + 12 + 5 + LONG_LEN + 1 + 30 + 8 + 10;

    logic          clk;
    logic          rst;
    rx_udp_hdr_t   rx_hdr;
    logic          rx_hdr_valid;
    logic          rx_hdr_ready;
    payload_beat_t rx_payload;
    logic          rx_payload_valid;
    logic          rx_payload_ready;
    tx_udp_hdr_t   tx_hdr;
    logic          tx_hdr_valid;
    logic          tx_hdr_ready;
    payload_beat_t tx_payload;
    logic          tx_payload_valid;
    logic          tx_payload_ready;
    logic [7:0]    led;

    tx_udp_hdr_t   exp_hdr_q[$];
    payload_beat_t exp_beat_q[$];
    tx_udp_hdr_t   exp_h;
    payload_beat_t exp_b;
    logic [7:0]    exp_led;
    logic          led_first;      // Next reply beat opens a datagram
    logic [7:0]    sent_first;     // First byte of the latest echoed datagram
    logic          random_ready;
    logic          hold_payload;   // Reply payload held off entirely
    int            hdr_errors;
    int            beat_errors;
    int            led_errors;
    int            misc_errors;

    `include "udp_echo_tasks.svh"

    udp_echo_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Output back-pressure
    always @(posedge clk) begin
        tx_hdr_ready <= random_ready ? (($urandom % 3) != 0) : 1'b1;
        if (hold_payload) begin
            tx_payload_ready <= 1'b0;
        end else begin
            tx_payload_ready <= random_ready ? (($urandom % 2) != 0) : 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            assert (exp_hdr_q.size() != 0) else begin
                misc_errors++;
                $display("Reply header at %0t while no echoed datagram was pending", $time);
            end
            if (exp_hdr_q.size() != 0) begin
                exp_h = exp_hdr_q.pop_front();
                assert (tx_hdr == exp_h) else begin
                    hdr_errors++;
                    $display("[ERROR] %0t: reply header %h, expected %h", $time, tx_hdr, exp_h);
                end
            end
        end
    end

    // Payload order and the LED model
    always @(posedge clk) begin
        if (!rst) begin
            assert (led == exp_led) else begin
                led_errors++;
                $display("[ERROR] %0t: led %h, expected %h", $time, led, exp_led);
            end
            if (tx_payload_valid && tx_payload_ready) begin
                assert (exp_beat_q.size() != 0) else begin
                    misc_errors++;
                    $display("Reply payload at %0t while no payload was pending", $time);
                end
                if (exp_beat_q.size() != 0) begin
                    exp_b = exp_beat_q.pop_front();
                    assert (tx_payload == exp_b) else begin
                        beat_errors++;
                        $display("[ERROR] %0t: payload beat %h, expected %h",
                                 $time, tx_payload, exp_b);
                    end
                    if (led_first) exp_led = exp_b.data;
                    led_first = exp_b.last;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hbaa0));
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        random_ready     = 1'b0;
        hold_payload     = 1'b0;
        exp_led          = 8'h00;
        led_first        = 1'b1;
        sent_first       = 8'h00;
        hdr_errors       = 0;
        beat_errors      = 0;
        led_errors       = 0;
        misc_errors      = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_single_echo();
        test_drop_then_echo();
        test_backpressure();
        test_led_hold();
        $display("Errors: header %0d, payload %0d, led %0d, other %0d",
                 hdr_errors, beat_errors, led_errors, misc_errors);
        if (hdr_errors + beat_errors + led_errors + misc_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Generous bound per byte plus setup time
    initial begin
        repeat (TOTAL_BYTES * 20 + 2000) @(posedge clk);
        $display("Timeout, the tests did not finish within %0d cycles",
                 TOTAL_BYTES * 20 + 2000);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
udp_hdr_pkg.sv
stream_pkg.sv
port_filter.sv
reply_hdr_reg.sv
payload_fifo.sv
led_capture.sv
udp_echo_top.sv
tb_udp_echo.sv

// ==== Bender.yml ====
package:
  name: udp_echo

sources:
  - include_dirs:
      - .
    files:
      - udp_hdr_pkg.sv
      - stream_pkg.sv
      - port_filter.sv
      - reply_hdr_reg.sv
      - payload_fifo.sv
      - led_capture.sv
      - udp_echo_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_udp_echo.sv
